//--- common/sched_pkg.sv
// Task scheduler package with widths, header and command field offsets,
// acknowledge codes, packed structs and FSM state encodings
package sched_pkg;

    localparam int MAX_ACCS      = 16;
    localparam int ACC_BITS      = 4;
    localparam int SUBQUEUE_BITS = 6;   // 64 slots per accelerator
    localparam int CMD_ADDR_BITS = ACC_BITS + SUBQUEUE_BITS;
    localparam int MAX_TYPES     = 8;
    localparam int TYPE_IDX_BITS = 3;

    // Command header fields and the argument count shared with the packet header
    localparam int CMD_TYPE_L         = 0;
    localparam int NUM_ARGS_OFFSET    = 8;
    localparam int DESTID_L           = 32;
    localparam int COMPF_L            = 40;
    localparam int ENTRY_VALID_OFFSET = 63;

    // Argument flags word
    localparam int ARG_FLAG_L = 4;
    localparam int ARG_IDX_L  = 8;
    localparam logic [1:0] DEFAULT_ARG_FLAGS = 2'b11;

    typedef logic [63:0]              word_t;
    typedef logic [ACC_BITS-1:0]      acc_id_t;
    typedef logic [SUBQUEUE_BITS-1:0] slot_t;
    typedef logic [SUBQUEUE_BITS:0]   slots_t;
    typedef logic [33:0]              task_type_t;
    typedef logic [3:0]               nargs_t;
    typedef logic [CMD_ADDR_BITS-1:0] cmd_addr_t;

    localparam word_t ACK_OK_CODE     = 64'h1;
    localparam word_t ACK_REJECT_CODE = 64'h0;
    localparam logic [27:0] TASK_ID_PREFIX = 28'hF000000;

    typedef struct packed {
        task_type_t task_type;
        acc_id_t    first_acc;
        acc_id_t    last_off;   // group size minus one
    } sched_entry_t;

    typedef struct packed {
        word_t      task_id;
        word_t      parent_id;
        task_type_t task_type;
        nargs_t     nargs;
        acc_id_t    src_id;
    } task_desc_t;

    typedef enum logic [1:0] {
        DEC_HEADER,
        DEC_PARENT,
        DEC_TYPE,
        DEC_BODY
    } decode_state_t;

    typedef enum logic [3:0] {
        CW_IDLE,
        CW_CHECK,
        CW_READ,
        CW_TASK_ID,
        CW_PARENT_ID,
        CW_FLAG,
        CW_ARG,
        CW_HEADER,
        CW_NOTIFY,
        CW_DRAIN,
        CW_ACK
    } cmd_state_t;

endpackage

//--- src/task_decode.sv
// Packet header decoding, task ID generation and argument forwarding
module task_decode (
    input  logic                  clk,
    input  logic                  rstn,
    input  sched_pkg::word_t      in_data,
    input  logic                  in_valid,
    input  logic                  in_last,
    input  sched_pkg::acc_id_t    in_id,
    output logic                  in_ready,
    output logic                  desc_valid,
    output sched_pkg::task_desc_t desc,
    input  logic                  arg_take,
    input  logic                  drain,
    output logic                  arg_valid,
    output logic                  arg_last,
    output sched_pkg::word_t      arg_word,
    output logic                  drain_done,
    input  logic                  task_done
);

    sched_pkg::decode_state_t state;
    logic [31:0]              id_count;
    logic                     pkt_end;   // in_last already seen for this packet
    logic                     in_fire;

    always_comb begin
        if (state == sched_pkg::DEC_BODY) begin
            in_ready = !pkt_end && (arg_take || drain);
        end else begin
            in_ready = 1'b1;
        end
    end

    assign in_fire    = in_valid && in_ready;
    assign arg_valid  = state == sched_pkg::DEC_BODY && arg_take && in_fire;
    assign arg_word   = in_data;
    assign arg_last   = in_last;
    assign drain_done = state == sched_pkg::DEC_BODY && drain && (pkt_end || (in_fire && in_last));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= sched_pkg::DEC_HEADER;
            id_count   <= '0;
            pkt_end    <= 1'b0;
            desc_valid <= 1'b0;
        end else begin
            desc_valid <= 1'b0;
            case (state)
                sched_pkg::DEC_HEADER: begin
                    if (in_fire) begin
                        id_count <= id_count + 1'b1;
                        state    <= sched_pkg::DEC_PARENT;
                    end
                end
                sched_pkg::DEC_PARENT: begin
                    if (in_fire) state <= sched_pkg::DEC_TYPE;
                end
                sched_pkg::DEC_TYPE: begin
                    if (in_fire) begin
                        desc_valid <= 1'b1;
                        pkt_end    <= in_last;   // no argument words follow
                        state      <= sched_pkg::DEC_BODY;
                    end
                end
                default: begin
                    if (in_fire && in_last) pkt_end <= 1'b1;
                    if (task_done) begin
                        pkt_end <= 1'b0;
                        state   <= sched_pkg::DEC_HEADER;
                    end
                end
            endcase
        end
    end

    // Descriptor fields held until the next header
    always_ff @(posedge clk) begin
        if (in_fire) begin
            case (state)
                sched_pkg::DEC_HEADER: begin
                    desc.task_id <= {sched_pkg::TASK_ID_PREFIX, id_count, 4'hF};
                    desc.nargs   <= in_data[sched_pkg::NUM_ARGS_OFFSET +: 4];
                    desc.src_id  <= in_id;
                end
                sched_pkg::DEC_PARENT: desc.parent_id <= in_data;
                sched_pkg::DEC_TYPE:   desc.task_type <= in_data[33:0];
                default: begin
                end
            endcase
        end
    end

    // Writer never asks for arguments and a drain at once
    assert property (@(posedge clk) disable iff (!rstn) arg_valid |-> arg_take && !drain);

endmodule

//--- src/acc_select.sv
// Scheduling table, in-order type search and round-robin accelerator choice
module acc_select (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    cfg_we,
    input  logic [sched_pkg::TYPE_IDX_BITS-1:0] cfg_idx,
    input  sched_pkg::sched_entry_t cfg_entry,
    input  logic                    desc_valid,
    input  sched_pkg::task_type_t   task_type,
    output logic                    sel_hit,
    output logic                    sel_miss,
    output sched_pkg::acc_id_t      sel_acc
);

    sched_pkg::sched_entry_t             table_q [sched_pkg::MAX_TYPES];
    sched_pkg::acc_id_t                  rr_off  [sched_pkg::MAX_TYPES];
    logic [sched_pkg::MAX_TYPES-1:0]     loaded;
    logic [sched_pkg::TYPE_IDX_BITS-1:0] idx;
    logic [sched_pkg::TYPE_IDX_BITS-1:0] cur_idx;
    logic                                searching;
    logic                                active;
    logic                                match;
    sched_pkg::sched_entry_t             cur;

    // Entry 0 is compared in the desc_valid cycle itself
    assign active  = desc_valid || searching;
    assign cur_idx = desc_valid ? '0 : idx;
    assign cur     = table_q[cur_idx];
    assign match   = active && loaded[cur_idx] && cur.task_type == task_type;

    always_ff @(posedge clk) begin
        if (cfg_we) table_q[cfg_idx] <= cfg_entry;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            loaded    <= '0;
            searching <= 1'b0;
            idx       <= '0;
            sel_hit   <= 1'b0;
            sel_miss  <= 1'b0;
            for (int i = 0; i < sched_pkg::MAX_TYPES; i++) begin
                rr_off[i] <= '0;
            end
        end else begin
            sel_hit  <= 1'b0;
            sel_miss <= 1'b0;
            if (cfg_we) begin
                loaded[cfg_idx] <= 1'b1;
                rr_off[cfg_idx] <= '0;
            end
            if (match) begin
                sel_hit         <= 1'b1;
                searching       <= 1'b0;
                rr_off[cur_idx] <= (rr_off[cur_idx] == cur.last_off) ? '0 : rr_off[cur_idx] + 1'b1;
            end else if (active) begin
                if (cur_idx == sched_pkg::MAX_TYPES - 1) begin
                    sel_miss  <= 1'b1;   // whole table searched
                    searching <= 1'b0;
                end else begin
                    searching <= 1'b1;
                    idx       <= cur_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (match) sel_acc <= cur.first_acc + rr_off[cur_idx];
    end

endmodule

//--- src/cmd_writer.sv
// Subqueue bookkeeping, slot reclaim, command memory writes,
// queue-not-empty pulse and acknowledge
module cmd_writer (
    input  logic                  clk,
    input  logic                  rstn,
    input  sched_pkg::task_desc_t desc,
    input  logic                  sel_hit,
    input  logic                  sel_miss,
    input  sched_pkg::acc_id_t    sel_acc,
    output logic                  arg_take,
    output logic                  drain,
    input  logic                  arg_valid,
    input  logic                  arg_last,
    input  sched_pkg::word_t      arg_word,
    input  logic                  drain_done,
    output logic                  task_done,
    output sched_pkg::cmd_addr_t  cmd_addr,
    output logic                  cmd_en,
    output logic                  cmd_we,
    output sched_pkg::word_t      cmd_din,
    input  sched_pkg::word_t      cmd_dout,
    output logic                  nempty_write,
    output sched_pkg::acc_id_t    nempty_acc,
    output sched_pkg::word_t      out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output sched_pkg::acc_id_t    out_dest
);

    typedef struct packed {
        sched_pkg::slot_t  r_idx;   // oldest task not yet reclaimed
        sched_pkg::slot_t  w_idx;   // where the next task starts
        sched_pkg::slots_t avail;
    } subq_t;

    subq_t                 subq [sched_pkg::MAX_ACCS];
    subq_t                 cur;   // working copy for the chosen accelerator
    sched_pkg::cmd_state_t state;
    sched_pkg::acc_id_t    acc;
    sched_pkg::slots_t     need;
    sched_pkg::slots_t     freed;
    sched_pkg::slot_t      ptr;
    sched_pkg::slot_t      slot;
    sched_pkg::nargs_t     arg_idx;
    sched_pkg::word_t      arg_buf;
    logic                  buf_last;
    logic                  accepted;

    assign need  = 7'd3 + {2'b00, desc.nargs, 1'b0};
    assign freed = 7'd3 + {2'b00, cmd_dout[sched_pkg::NUM_ARGS_OFFSET +: 4], 1'b0};

    always_comb begin
        slot    = ptr;
        cmd_en  = 1'b0;
        cmd_we  = 1'b0;
        cmd_din = desc.task_id;
        case (state)
            sched_pkg::CW_CHECK: begin
                slot   = cur.r_idx;
                cmd_en = need > cur.avail;   // read oldest header
            end
            sched_pkg::CW_TASK_ID: begin
                cmd_en = 1'b1;
                cmd_we = 1'b1;
            end
            sched_pkg::CW_PARENT_ID: begin
                cmd_en  = 1'b1;
                cmd_we  = 1'b1;
                cmd_din = desc.parent_id;
            end
            sched_pkg::CW_FLAG: begin
                cmd_en  = arg_valid;
                cmd_we  = arg_valid;
                cmd_din = '0;
                cmd_din[sched_pkg::ARG_IDX_L +: 4]  = arg_idx;
                cmd_din[sched_pkg::ARG_FLAG_L +: 2] = sched_pkg::DEFAULT_ARG_FLAGS;
            end
            sched_pkg::CW_ARG: begin
                cmd_en  = 1'b1;
                cmd_we  = 1'b1;
                cmd_din = arg_buf;
            end
            sched_pkg::CW_HEADER: begin
                slot    = cur.w_idx;
                cmd_en  = 1'b1;
                cmd_we  = 1'b1;
                cmd_din = '0;
                cmd_din[sched_pkg::ENTRY_VALID_OFFSET]    = 1'b1;
                cmd_din[sched_pkg::CMD_TYPE_L +: 8]       = 8'h01;
                cmd_din[sched_pkg::DESTID_L +: 8]         = 8'h11;
                cmd_din[sched_pkg::COMPF_L +: 8]          = 8'h01;
                cmd_din[sched_pkg::NUM_ARGS_OFFSET +: 4]  = desc.nargs;
            end
            default: begin
            end
        endcase
    end

    assign cmd_addr     = {acc, slot};
    assign arg_take     = state == sched_pkg::CW_FLAG;
    assign drain        = state == sched_pkg::CW_DRAIN;
    assign nempty_write = state == sched_pkg::CW_NOTIFY;
    assign nempty_acc   = acc;
    assign out_valid    = state == sched_pkg::CW_ACK;
    assign out_data     = accepted ? sched_pkg::ACK_OK_CODE : sched_pkg::ACK_REJECT_CODE;
    assign out_dest     = desc.src_id;
    assign task_done    = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= sched_pkg::CW_IDLE;
            accepted <= 1'b0;
            for (int i = 0; i < sched_pkg::MAX_ACCS; i++) begin
                subq[i] <= '{r_idx: '0, w_idx: '0, avail: 7'd64};
            end
        end else begin
            case (state)
                sched_pkg::CW_IDLE: begin
                    accepted <= 1'b0;
                    if (sel_hit) state <= sched_pkg::CW_CHECK;
                    else if (sel_miss) state <= sched_pkg::CW_DRAIN;
                end
                sched_pkg::CW_CHECK: begin
                    state <= (need <= cur.avail) ? sched_pkg::CW_TASK_ID : sched_pkg::CW_READ;
                end
                sched_pkg::CW_READ: begin
                    // Oldest task still pending means no room
                    if (cmd_dout[sched_pkg::ENTRY_VALID_OFFSET]) state <= sched_pkg::CW_DRAIN;
                    else state <= sched_pkg::CW_CHECK;
                end
                sched_pkg::CW_TASK_ID: state <= sched_pkg::CW_PARENT_ID;
                sched_pkg::CW_PARENT_ID: begin
                    state <= (desc.nargs != 0) ? sched_pkg::CW_FLAG : sched_pkg::CW_HEADER;
                end
                sched_pkg::CW_FLAG: begin
                    if (arg_valid) state <= sched_pkg::CW_ARG;
                end
                sched_pkg::CW_ARG: begin
                    state <= buf_last ? sched_pkg::CW_HEADER : sched_pkg::CW_FLAG;
                end
                sched_pkg::CW_HEADER: begin
                    subq[acc] <= '{r_idx: cur.r_idx,
                                   w_idx: cur.w_idx + need[5:0],
                                   avail: cur.avail - need};
                    accepted  <= 1'b1;
                    state     <= sched_pkg::CW_NOTIFY;
                end
                sched_pkg::CW_NOTIFY: state <= sched_pkg::CW_ACK;
                sched_pkg::CW_DRAIN: begin
                    if (drain_done) state <= sched_pkg::CW_ACK;
                end
                default: begin
                    if (out_ready) state <= sched_pkg::CW_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            sched_pkg::CW_IDLE: begin
                if (sel_hit) begin
                    acc <= sel_acc;
                    cur <= subq[sel_acc];
                end
            end
            sched_pkg::CW_CHECK: begin
                ptr     <= cur.w_idx + 1'b1;   // header slot filled last
                arg_idx <= '0;
            end
            sched_pkg::CW_READ: begin
                if (!cmd_dout[sched_pkg::ENTRY_VALID_OFFSET]) begin
                    cur.r_idx <= cur.r_idx + freed[5:0];
                    cur.avail <= cur.avail + freed;
                end
            end
            sched_pkg::CW_TASK_ID, sched_pkg::CW_PARENT_ID: ptr <= ptr + 1'b1;
            sched_pkg::CW_FLAG: begin
                if (arg_valid) begin
                    ptr      <= ptr + 1'b1;
                    arg_buf  <= arg_word;
                    buf_last <= arg_last;
                end
            end
            sched_pkg::CW_ARG: begin
                ptr     <= ptr + 1'b1;
                arg_idx <= arg_idx + 1'b1;
            end
            default: begin
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest));

    assert property (@(posedge clk) disable iff (!rstn) cmd_we |-> cmd_en);

endmodule

//--- src/task_scheduler.sv
// Task scheduler top level
// Connects packet decoder, accelerator selector and command writer
module task_scheduler (
    input  logic                    clk,
    input  logic                    rstn,
    // New-task input stream
    input  sched_pkg::word_t        in_data,
    input  logic                    in_valid,
    input  logic                    in_last,
    input  sched_pkg::acc_id_t      in_id,
    output logic                    in_ready,
    // Acknowledge stream
    output sched_pkg::word_t        out_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output sched_pkg::acc_id_t      out_dest,
    // Command memory
    output sched_pkg::cmd_addr_t    cmd_addr,
    output logic                    cmd_en,
    output logic                    cmd_we,
    output sched_pkg::word_t        cmd_din,
    input  sched_pkg::word_t        cmd_dout,
    // Queue not empty
    output logic                    nempty_write,
    output sched_pkg::acc_id_t      nempty_acc,
    // Scheduling table load
    input  logic                    cfg_we,
    input  logic [sched_pkg::TYPE_IDX_BITS-1:0] cfg_idx,
    input  sched_pkg::sched_entry_t cfg_entry
);

    sched_pkg::task_desc_t desc;
    logic                  desc_valid;
    logic                  sel_hit;
    logic                  sel_miss;
    sched_pkg::acc_id_t    sel_acc;
    logic                  arg_take;
    logic                  drain;
    logic                  arg_valid;
    logic                  arg_last;
    sched_pkg::word_t      arg_word;
    logic                  drain_done;
    logic                  task_done;

    task_decode u_task_decode (
        .*
    );

    acc_select u_acc_select (
        .task_type(desc.task_type),
        .*
    );

    cmd_writer u_cmd_writer (
        .*
    );

endmodule

//--- testbench/sched_tests.svh
// Directed scheduler tests with packet send, acknowledge wait and table load helpers
localparam sched_pkg::task_type_t TYPE_A       = 34'h1_0000_0001;   // acc 2
localparam sched_pkg::task_type_t TYPE_B       = 34'h2_1234_5678;   // accs 5 to 7
localparam sched_pkg::task_type_t TYPE_C       = 34'h0_0000_0042;   // acc 9
localparam sched_pkg::task_type_t TYPE_UNKNOWN = 34'h3_dead_beef;

task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

function automatic sched_pkg::cmd_addr_t slot_addr(input sched_pkg::acc_id_t acc,
                                                   input int slot);
    logic [5:0] s;
    s = slot[5:0];   // subqueue wraps modulo 64
    return {acc, s};
endfunction

task automatic load_entry(input int idx, input sched_pkg::task_type_t ttype,
                          input sched_pkg::acc_id_t first, input sched_pkg::acc_id_t last);
    cfg_idx   = idx[2:0];
    cfg_entry = '{task_type: ttype, first_acc: first, last_off: last};
    cfg_we    = 1'b1;
    next_cycle();
    cfg_we    = 1'b0;
endtask

task automatic load_table();
    load_entry(0, TYPE_A, 4'h2, 4'h0);
    load_entry(1, TYPE_B, 4'h5, 4'h2);
    load_entry(5, TYPE_C, 4'h9, 4'h0);   // found after a longer search
endtask

task automatic clear_header(input sched_pkg::cmd_addr_t a);
    clear_addr = a;
    clear_req  = 1'b1;
    next_cycle();
    clear_req  = 1'b0;
endtask

task automatic send_word(input sched_pkg::word_t data, input logic last);
    logic taken;
    in_data  = data;
    in_last  = last;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
        @(negedge clk);
        taken = in_ready;
        next_cycle();
    end
endtask

task automatic wait_ack(input int hold, output sched_pkg::word_t data,
                        output sched_pkg::acc_id_t dest);
    @(negedge clk);
    while (!out_valid) @(negedge clk);
    data = out_data;
    dest = out_dest;
    for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        if (out_valid !== 1'b1) report_failure("out_valid dropped before out_ready");
        if (out_data !== data) report_mismatch("out_data", out_data, data);
        if (in_ready !== 1'b0) report_failure("in_ready high while acknowledge is pending");
    end
    if (hold > 0) begin
        next_cycle();
        out_ready = 1'b1;
    end
    next_cycle();
endtask

task automatic run_task(input sched_pkg::task_type_t ttype, input int nargs,
                        input sched_pkg::acc_id_t src, input sched_pkg::acc_id_t exp_acc,
                        input logic exp_ok, input int hold);
    sched_pkg::word_t   args [16];
    sched_pkg::word_t   parent;
    sched_pkg::word_t   hdr;
    sched_pkg::word_t   exp_id;
    sched_pkg::word_t   exp_hdr;
    sched_pkg::word_t   exp_flag;
    sched_pkg::word_t   ack_data;
    sched_pkg::acc_id_t ack_dest;
    int                 wr_base;
    int                 nemp_base;
    int                 w;
    get_random_word(parent);
    for (int k = 0; k < nargs; k++) get_random_word(args[k]);
    exp_id      = {sched_pkg::TASK_ID_PREFIX, next_id_num, 4'hF};
    next_id_num = next_id_num + 1;
    wr_base     = wr_log.size();
    nemp_base   = nempty_count;
    w           = wptr[exp_acc];
    hdr         = '0;
    hdr[sched_pkg::NUM_ARGS_OFFSET +: 4] = nargs[3:0];
    if (hold > 0) out_ready = 1'b0;
    in_id = src;
    send_word(hdr, 1'b0);
    send_word(parent, 1'b0);
    send_word({30'h0, ttype}, nargs == 0);
    for (int k = 0; k < nargs; k++) send_word(args[k], k == nargs - 1);
    in_valid = 1'b0;
    in_last  = 1'b0;
    wait_ack(hold, ack_data, ack_dest);
    if (ack_dest !== src) report_mismatch("out_dest", ack_dest, src);
    if (!exp_ok) begin
        if (ack_data !== sched_pkg::ACK_REJECT_CODE) begin
            report_mismatch("out_data", ack_data, sched_pkg::ACK_REJECT_CODE);
        end
        if (wr_log.size() != wr_base) report_failure("command writes for a rejected task");
        if (nempty_count != nemp_base) report_failure("nempty_write for a rejected task");
        return;
    end
    if (ack_data !== sched_pkg::ACK_OK_CODE) begin
        report_mismatch("out_data", ack_data, sched_pkg::ACK_OK_CODE);
    end
    if (wr_log.size() != wr_base + 3 + 2 * nargs) begin
        report_failure("wrong number of command memory writes");
    end else begin
        for (int k = 0; k < 2 + 2 * nargs; k++) begin
            if (wr_log[wr_base + k] !== slot_addr(exp_acc, w + 1 + k)) begin
                report_mismatch("cmd_addr", sched_pkg::word_t'(wr_log[wr_base + k]),
                                sched_pkg::word_t'(slot_addr(exp_acc, w + 1 + k)));
            end
        end
        if (wr_log[wr_log.size() - 1] !== slot_addr(exp_acc, w)) begin
            report_failure("command header was not the last write");
        end
    end
    exp_hdr = '0;
    exp_hdr[sched_pkg::ENTRY_VALID_OFFSET]   = 1'b1;
    exp_hdr[sched_pkg::CMD_TYPE_L +: 8]      = 8'h01;
    exp_hdr[sched_pkg::DESTID_L +: 8]        = 8'h11;
    exp_hdr[sched_pkg::COMPF_L +: 8]         = 8'h01;
    exp_hdr[sched_pkg::NUM_ARGS_OFFSET +: 4] = nargs[3:0];
    if (mem[slot_addr(exp_acc, w)] !== exp_hdr) begin
        report_mismatch("cmd header", mem[slot_addr(exp_acc, w)], exp_hdr);
    end
    if (mem[slot_addr(exp_acc, w + 1)] !== exp_id) begin
        report_mismatch("cmd task id", mem[slot_addr(exp_acc, w + 1)], exp_id);
    end
    if (mem[slot_addr(exp_acc, w + 2)] !== parent) begin
        report_mismatch("cmd parent id", mem[slot_addr(exp_acc, w + 2)], parent);
    end
    for (int k = 0; k < nargs; k++) begin
        exp_flag = '0;
        exp_flag[sched_pkg::ARG_IDX_L +: 4]  = k[3:0];
        exp_flag[sched_pkg::ARG_FLAG_L +: 2] = sched_pkg::DEFAULT_ARG_FLAGS;
        if (mem[slot_addr(exp_acc, w + 3 + 2 * k)] !== exp_flag) begin
            report_mismatch("cmd arg flags", mem[slot_addr(exp_acc, w + 3 + 2 * k)], exp_flag);
        end
        if (mem[slot_addr(exp_acc, w + 4 + 2 * k)] !== args[k]) begin
            report_mismatch("cmd arg word", mem[slot_addr(exp_acc, w + 4 + 2 * k)], args[k]);
        end
    end
    if (nempty_count != nemp_base + 1) begin
        report_failure("expected exactly one nempty_write pulse");
    end else if (nempty_last !== exp_acc) begin
        report_mismatch("nempty_acc", nempty_last, exp_acc);
    end
    wptr[exp_acc] = (w + 3 + 2 * nargs) % 64;
endtask

task automatic check_after_reset();
    @(negedge clk);
    if (in_ready !== 1'b1) report_failure("in_ready low after reset");
    if (out_valid !== 1'b0) report_failure("out_valid high after reset");
    if (cmd_en !== 1'b0 || cmd_we !== 1'b0) report_failure("command memory active after reset");
    if (nempty_write !== 1'b0) report_failure("nempty_write high after reset");
    next_cycle();
endtask

task automatic test_no_args();
    run_task(TYPE_A, 0, 4'h3, 4'h2, 1'b1, 0);
    run_task(TYPE_A, 0, 4'hc, 4'h2, 1'b1, 0);
endtask

task automatic test_arguments();
    run_task(TYPE_A, 3, 4'h1, 4'h2, 1'b1, 0);
    run_task(TYPE_A, 0, 4'h1, 4'h2, 1'b1, 0);   // starts 9 slots later
endtask

task automatic test_round_robin();
    for (int i = 0; i < 6; i++) begin
        run_task(TYPE_B, i % 2, 4'h6, sched_pkg::acc_id_t'(5 + i % 3), 1'b1, 0);
    end
endtask

task automatic test_unknown_type();
    run_task(TYPE_UNKNOWN, 2, 4'h9, 4'h0, 1'b0, 0);
    run_task(TYPE_A, 1, 4'h9, 4'h2, 1'b1, 0);
endtask

task automatic test_full_reclaim();
    // Seven 9-slot tasks leave one free slot
    for (int i = 0; i < 7; i++) run_task(TYPE_C, 3, 4'h4, 4'h9, 1'b1, 0);
    run_task(TYPE_C, 1, 4'h4, 4'h9, 1'b0, 0);
    clear_header(slot_addr(4'h9, 0));
    run_task(TYPE_C, 0, 4'h4, 4'h9, 1'b1, 0);   // wraps into slots 63, 0, 1
endtask

task automatic test_backpressure();
    run_task(TYPE_A, 0, 4'h7, 4'h2, 1'b1, 5);
endtask

//--- testbench/tb_task_scheduler.sv
// Task scheduler testbench top with clock, reset, command memory model,
// DUT instance, watchdog and final report
module tb_task_scheduler;

    localparam int CLK_PERIOD        = 100;
    localparam int DRIVE_DELAY       = 10;
    localparam int RESET_CYCLES      = 16;
    localparam int NUM_PACKETS       = 22;
    localparam int PER_PACKET_CYCLES = 100;
    localparam int MEM_WORDS         = 1024;

    logic                    clk;
    logic                    rstn;
    sched_pkg::word_t        in_data;
    logic                    in_valid;
    logic                    in_last;
    sched_pkg::acc_id_t      in_id;
    logic                    in_ready;
    sched_pkg::word_t        out_data;
    logic                    out_valid;
    logic                    out_ready;
    sched_pkg::acc_id_t      out_dest;
    sched_pkg::cmd_addr_t    cmd_addr;
    logic                    cmd_en;
    logic                    cmd_we;
    sched_pkg::word_t        cmd_din;
    sched_pkg::word_t        cmd_dout;
    logic                    nempty_write;
    sched_pkg::acc_id_t      nempty_acc;
    logic                    cfg_we;
    logic [sched_pkg::TYPE_IDX_BITS-1:0] cfg_idx;
    sched_pkg::sched_entry_t cfg_entry;

    // Command memory model
    sched_pkg::word_t     mem [MEM_WORDS];
    sched_pkg::cmd_addr_t wr_log [$];   // write addresses in order
    logic                 clear_req;
    sched_pkg::cmd_addr_t clear_addr;

    int                 mismatch_count;
    int                 failure_count;
    int                 nempty_count;
    sched_pkg::acc_id_t nempty_last;
    logic [31:0]        rng_state;
    logic [31:0]        next_id_num;
    int                 wptr [sched_pkg::MAX_ACCS];   // expected next start slot

    task_scheduler u_task_scheduler (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= {22'h0, i[9:0], 22'h15a5a5, i[9:0]};
            end
        end else begin
            if (cmd_en && cmd_we) begin
                mem[cmd_addr] <= cmd_din;
                wr_log.push_back(cmd_addr);
            end else if (cmd_en) begin
                cmd_dout <= mem[cmd_addr];   // one cycle read latency
            end
            if (clear_req) mem[clear_addr][sched_pkg::ENTRY_VALID_OFFSET] <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rstn && nempty_write) begin
            nempty_count = nempty_count + 1;
            nempty_last  = nempty_acc;
            if (out_valid) report_failure("nempty_write pulse while out_valid is high");
        end
    end

    task automatic report_mismatch(input string name, input sched_pkg::word_t got,
                                   input sched_pkg::word_t exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        mismatch_count = mismatch_count + 1;
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        failure_count = failure_count + 1;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic get_random_word(output sched_pkg::word_t w);
        logic [31:0] hi;
        rng_state = xorshift32(rng_state);
        hi        = rng_state;
        rng_state = xorshift32(rng_state);
        w         = {hi, rng_state};
    endtask

    `include "sched_tests.svh"

    initial begin
        rstn           = 1'b0;
        in_data        = '0;
        in_valid       = 1'b0;
        in_last        = 1'b0;
        in_id          = '0;
        out_ready      = 1'b1;
        cmd_dout       = '0;
        cfg_we         = 1'b0;
        cfg_idx        = '0;
        cfg_entry      = '0;
        clear_req      = 1'b0;
        clear_addr     = '0;
        mismatch_count = 0;
        failure_count  = 0;
        nempty_count   = 0;
        nempty_last    = '0;
        rng_state      = 32'h65562a1e;
        next_id_num    = '0;
        for (int i = 0; i < sched_pkg::MAX_ACCS; i++) begin
            wptr[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        check_after_reset();
        load_table();
        test_no_args();
        test_arguments();
        test_round_robin();
        test_unknown_type();
        test_full_reclaim();
        test_backpressure();
        repeat (4) next_cycle();
        $display("Mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Bound on the whole run from packet count and reset length
    initial begin
        #((RESET_CYCLES + 50 + NUM_PACKETS * PER_PACKET_CYCLES) * CLK_PERIOD);
        report_failure("watchdog expired before the tests completed");
        $display("Mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+testbench
common/sched_pkg.sv
src/task_decode.sv
src/acc_select.sv
src/cmd_writer.sv
src/task_scheduler.sv
testbench/tb_task_scheduler.sv

//--- Makefile
# Verilator build and run for the task scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_task_scheduler
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
